// ==== hw/rtc_config.svh ====
`ifndef RTC_CONFIG_SVH
`define RTC_CONFIG_SVH

// Data widths
`define RTC_BITS_BCD 8
`define RTC_BITS_BIN 7
`define RTC_BITS_IDX 4

// Held button repeat, in clock cycles
`define RTC_REPETICION 600

// Cursor runs 0..2
`define RTC_POS_MAX 2

// Field limits
`define RTC_MAX_SEG 59
`define RTC_MAX_MIN 59
`define RTC_MAX_HORA 23
`define RTC_MAX_DIA 31
`define RTC_MAX_MES 12
`define RTC_MAX_ANO 99
`define RTC_MIN_DIA 1
`define RTC_MIN_MES 1

`endif

// ==== hw/rtc_pkg.sv ====
`include "rtc_config.svh"

package rtc_pkg;

    typedef enum logic [1:0] {
        MODO_NINGUNO,
        MODO_FECHA,
        MODO_HORA,
        MODO_TEMP
    } modo_t;

    typedef enum logic [1:0] {
        OP_NADA,
        OP_SUMAR,
        OP_RESTAR
    } op_t;

    // Time, then date, then countdown timer
    typedef enum logic [`RTC_BITS_IDX-1:0] {
        SEG_H, MIN_H, HORA_H,
        DIA_F, MES_F, ANO_F,
        SEG_T, MIN_T, HORA_T
    } campo_t;

    function automatic logic bcd_valido(input logic [`RTC_BITS_BCD-1:0] b);
        return (b[7:4] <= 4'd9) && (b[3:0] <= 4'd9);
    endfunction

    function automatic logic [`RTC_BITS_BIN-1:0] bcd_a_bin(input logic [`RTC_BITS_BCD-1:0] b);
        logic [`RTC_BITS_BIN-1:0] dec;
        logic [`RTC_BITS_BIN-1:0] uni;
        dec = '0;
        uni = '0;
        dec[3:0] = b[7:4];
        uni[3:0] = b[3:0];
        return dec * 7'd10 + uni;
    endfunction

    // Input must be below 100
    function automatic logic [`RTC_BITS_BCD-1:0] bin_a_bcd(input logic [`RTC_BITS_BIN-1:0] v);
        logic [`RTC_BITS_BIN-1:0] dec;
        logic [`RTC_BITS_BIN-1:0] uni;
        dec = v / 7'd10;
        uni = v - dec * 7'd10;
        return {dec[3:0], uni[3:0]};
    endfunction

endpackage

// ==== hw/botones_if.sv ====
`timescale 1ns/100ps

// One-cycle button pulses, at most one high at a time
interface botones_if;

    logic sumar;
    logic restar;
    logic derecha;
    logic izquierda;

    modport emisor (
        output sumar, restar, derecha, izquierda
    );

    modport receptor (
        input sumar, restar, derecha, izquierda
    );

endinterface

// ==== hw/boton_pulsos.sv ====
`timescale 1ns/100ps
`include "rtc_config.svh"

module boton_pulsos (
    input  logic RELOJ,
    input  logic RESET,
    input  logic sumar,
    input  logic restar,
    input  logic derecha,
    input  logic izquierda,
    botones_if.emisor pulsos
);

    localparam int ANCHO = $clog2(`RTC_REPETICION + 1);
    localparam logic [ANCHO-1:0] LIMITE = `RTC_REPETICION;

    // Bit order: sumar, restar, derecha, izquierda
    logic [3:0] sinc;
    logic [3:0] previo;
    logic [3:0] flanco;
    logic [3:0] candidato;
    logic [ANCHO-1:0] contador;
    logic repetir;
    logic disparo;

    assign flanco = sinc & ~previo;
    assign repetir = (|sinc) && (contador == LIMITE);
    assign disparo = (|flanco) || repetir;

    // New press selects among fresh edges, repeat among held buttons
    assign candidato = (|flanco) ? flanco : sinc;

    always_ff @(posedge RELOJ)
    begin
        if (RESET)
        begin
            sinc <= '0;
            previo <= '0;
            contador <= '0;
            pulsos.sumar <= 1'b0;
            pulsos.restar <= 1'b0;
            pulsos.derecha <= 1'b0;
            pulsos.izquierda <= 1'b0;
        end
        else
        begin
            sinc <= {sumar, restar, derecha, izquierda};
            previo <= sinc;

            // Fixed priority keeps the pulses one-hot
            pulsos.sumar <= disparo && candidato[3];
            pulsos.restar <= disparo && !candidato[3] && candidato[2];
            pulsos.derecha <= disparo && (candidato[3:2] == 2'b00) && candidato[1];
            pulsos.izquierda <= disparo && (candidato[3:1] == 3'b000) && candidato[0];

            if (disparo)
                contador <= ANCHO'(1);
            else if (|sinc)
                contador <= contador + 1'b1;
            else
                contador <= '0;
        end
    end

endmodule

// ==== hw/selector_campo.sv ====
`timescale 1ns/100ps
`include "rtc_config.svh"

module selector_campo (
    input  logic RELOJ,
    input  logic RESET,
    input  logic p_fecha,
    input  logic p_hora,
    input  logic p_temp,
    botones_if.receptor pulsos,
    output rtc_pkg::op_t op,
    output rtc_pkg::campo_t campo
);

    localparam logic [1:0] POS_MAX = `RTC_POS_MAX;

    rtc_pkg::modo_t modo;
    rtc_pkg::campo_t base;
    rtc_pkg::campo_t destino;
    logic [1:0] cursor;

    ////////////////////////////////////////////////////////////////////////////
    // Mode decode
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        case ({p_fecha, p_hora, p_temp})
            3'b100: modo = rtc_pkg::MODO_FECHA;
            3'b010: modo = rtc_pkg::MODO_HORA;
            3'b001: modo = rtc_pkg::MODO_TEMP;
            default: modo = rtc_pkg::MODO_NINGUNO;
        endcase
    end

    // First field of the selected group
    always_comb
    begin
        case (modo)
            rtc_pkg::MODO_FECHA: base = rtc_pkg::DIA_F;
            rtc_pkg::MODO_TEMP: base = rtc_pkg::SEG_T;
            default: base = rtc_pkg::SEG_H;
        endcase
    end

    assign destino = rtc_pkg::campo_t'(base + cursor);

    ////////////////////////////////////////////////////////////////////////////
    // Cursor and operation
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge RELOJ)
    begin
        if (RESET)
        begin
            cursor <= '0;
            op <= rtc_pkg::OP_NADA;
        end
        else
        begin
            op <= rtc_pkg::OP_NADA;
            if (modo == rtc_pkg::MODO_NINGUNO)
                cursor <= '0;
            else if (pulsos.sumar)
                op <= rtc_pkg::OP_SUMAR;
            else if (pulsos.restar)
                op <= rtc_pkg::OP_RESTAR;
            else if (pulsos.derecha && cursor != 2'd0)
                cursor <= cursor - 1'b1;
            else if (pulsos.izquierda && cursor != POS_MAX)
                cursor <= cursor + 1'b1;
        end
    end

    // Only meaningful while op is active
    always_ff @(posedge RELOJ)
    begin
        campo <= destino;
    end

endmodule

// ==== hw/banco_registros.sv ====
`timescale 1ns/100ps
`include "rtc_config.svh"

module banco_registros (
    input  logic RELOJ,
    input  logic RESET,
    input  rtc_pkg::op_t op,
    input  rtc_pkg::campo_t campo,
    input  logic cargar,
    input  logic [`RTC_BITS_IDX-1:0] indice_dato,
    input  logic [`RTC_BITS_BCD-1:0] dato_in,
    output logic [`RTC_BITS_BCD-1:0] dato_out
);

    // Limits in field order
    localparam logic [`RTC_BITS_BIN-1:0] MAXIMO [9] = '{
        `RTC_MAX_SEG, `RTC_MAX_MIN, `RTC_MAX_HORA,
        `RTC_MAX_DIA, `RTC_MAX_MES, `RTC_MAX_ANO,
        `RTC_MAX_SEG, `RTC_MAX_MIN, `RTC_MAX_HORA
    };

    localparam logic [`RTC_BITS_BIN-1:0] MINIMO [9] = '{
        0, 0, 0,
        `RTC_MIN_DIA, `RTC_MIN_MES, 0,
        0, 0, 0
    };

    logic [`RTC_BITS_BIN-1:0] campos [9];
    logic [`RTC_BITS_BIN-1:0] actual;
    logic [`RTC_BITS_BIN-1:0] siguiente;
    logic [`RTC_BITS_BIN-1:0] valor_in;
    logic indice_ok;
    logic carga_ok;

    ////////////////////////////////////////////////////////////////////////////
    // Load check
    ////////////////////////////////////////////////////////////////////////////

    assign indice_ok = (indice_dato <= rtc_pkg::HORA_T);
    assign valor_in = rtc_pkg::bcd_a_bin(dato_in);

    assign carga_ok = cargar && indice_ok
                   && rtc_pkg::bcd_valido(dato_in)
                   && (valor_in >= MINIMO[indice_dato])
                   && (valor_in <= MAXIMO[indice_dato]);

    ////////////////////////////////////////////////////////////////////////////
    // Step with wrap
    ////////////////////////////////////////////////////////////////////////////

    assign actual = campos[campo];

    always_comb
    begin
        case (op)
            rtc_pkg::OP_SUMAR:
                siguiente = (actual >= MAXIMO[campo]) ? MINIMO[campo] : actual + 1'b1;
            rtc_pkg::OP_RESTAR:
                siguiente = (actual <= MINIMO[campo]) ? MAXIMO[campo] : actual - 1'b1;
            default:
                siguiente = actual;
        endcase
    end

    always_ff @(posedge RELOJ)
    begin
        if (RESET)
        begin
            for (int i = 0; i < 9; i++)
            begin
                campos[i] <= MINIMO[i];
            end
        end
        else
        begin
            if (op != rtc_pkg::OP_NADA)
                campos[campo] <= siguiente;
            // Load comes last so it overrides a step on the same field
            if (carga_ok)
                campos[indice_dato] <= valor_in;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // BCD readback
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge RELOJ)
    begin
        if (RESET)
            dato_out <= '0;
        else if (indice_ok)
            dato_out <= rtc_pkg::bin_a_bcd(campos[indice_dato]);
        else
            dato_out <= '0;
    end

endmodule

// ==== hw/rtc_ajuste_top.sv ====
`timescale 1ns/100ps
`include "rtc_config.svh"

module rtc_ajuste_top (
    input  logic RELOJ,
    input  logic RESET,
    input  logic P_FECHA,
    input  logic P_HORA,
    input  logic P_TEMP,
    input  logic SUMAR,
    input  logic RESTAR,
    input  logic DERECHA,
    input  logic IZQUIERDA,
    input  logic CARGAR,
    input  logic [`RTC_BITS_IDX-1:0] INDICE_DATO,
    input  logic [`RTC_BITS_BCD-1:0] DATO_IN,
    output logic [`RTC_BITS_BCD-1:0] DATO_OUT
);

    rtc_pkg::op_t op;
    rtc_pkg::campo_t campo;

    botones_if botones_i ();

    boton_pulsos boton_pulsos_i (
        .RELOJ     (RELOJ),
        .RESET     (RESET),
        .sumar     (SUMAR),
        .restar    (RESTAR),
        .derecha   (DERECHA),
        .izquierda (IZQUIERDA),
        .pulsos    (botones_i)
    );

    selector_campo selector_campo_i (
        .RELOJ   (RELOJ),
        .RESET   (RESET),
        .p_fecha (P_FECHA),
        .p_hora  (P_HORA),
        .p_temp  (P_TEMP),
        .pulsos  (botones_i),
        .op      (op),
        .campo   (campo)
    );

    banco_registros banco_registros_i (
        .RELOJ       (RELOJ),
        .RESET       (RESET),
        .op          (op),
        .campo       (campo),
        .cargar      (CARGAR),
        .indice_dato (INDICE_DATO),
        .dato_in     (DATO_IN),
        .dato_out    (DATO_OUT)
    );

endmodule

// ==== testbench/rtc_ajuste_tb.sv ====
`timescale 1ns/100ps
`include "rtc_config.svh"

module rtc_ajuste_tb;

    localparam logic [31:0] SEMILLA = 32'h036e_a081;
    localparam int NUM_CARGAS = 60;
    localparam int NUM_PRUEBAS = 40;
    localparam int CICLOS_TODO = 9 * 3;
    // Reset, index sweep, loads with readback, taps with full readback
    localparam int CICLOS_TEST = 4 + 16 * 3 + (NUM_CARGAS + 20) * (1 + CICLOS_TODO)
                               + (NUM_PRUEBAS + 40) * (13 + CICLOS_TODO + 2);
    localparam int TIMEOUT_NS = CICLOS_TEST * 2 * 20 + 5000;

    localparam int BOTON_SUMAR = 0;
    localparam int BOTON_RESTAR = 1;
    localparam int BOTON_DERECHA = 2;
    localparam int BOTON_IZQUIERDA = 3;

    logic RELOJ;
    logic RESET;
    logic p_fecha;
    logic p_hora;
    logic p_temp;
    logic sumar;
    logic restar;
    logic derecha;
    logic izquierda;
    logic cargar;
    logic [`RTC_BITS_IDX-1:0] indice_dato;
    logic [`RTC_BITS_BCD-1:0] dato_in;
    logic [`RTC_BITS_BCD-1:0] dato_out;

    logic [31:0] estado;
    int modelo [9];
    int cursor;

    rtc_ajuste_top dut_i (
        .RELOJ       (RELOJ),
        .RESET       (RESET),
        .P_FECHA     (p_fecha),
        .P_HORA      (p_hora),
        .P_TEMP      (p_temp),
        .SUMAR       (sumar),
        .RESTAR      (restar),
        .DERECHA     (derecha),
        .IZQUIERDA   (izquierda),
        .CARGAR      (cargar),
        .INDICE_DATO (indice_dato),
        .DATO_IN     (dato_in),
        .DATO_OUT    (dato_out)
    );

    always #10 RELOJ = ~RELOJ;

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic int maximo(input int idx);
        case (idx)
            0, 6: return `RTC_MAX_SEG;
            1, 7: return `RTC_MAX_MIN;
            2, 8: return `RTC_MAX_HORA;
            3: return `RTC_MAX_DIA;
            4: return `RTC_MAX_MES;
            default: return `RTC_MAX_ANO;
        endcase
    endfunction

    function automatic int minimo(input int idx);
        if (idx == 3)
            return `RTC_MIN_DIA;
        if (idx == 4)
            return `RTC_MIN_MES;
        return 0;
    endfunction

    // Step with wrap inside the field range
    function automatic int paso(input int v, input int idx, input bit subir);
        if (subir)
            return (v >= maximo(idx)) ? minimo(idx) : v + 1;
        return (v <= minimo(idx)) ? maximo(idx) : v - 1;
    endfunction

    function automatic int a_bcd(input int v);
        return (v / 10) * 16 + (v % 10);
    endfunction

    function automatic bit carga_valida(input int idx, input logic [7:0] b);
        int val;
        val = int'(b[7:4]) * 10 + int'(b[3:0]);
        return (idx <= 8) && (b[7:4] <= 4'd9) && (b[3:0] <= 4'd9)
            && (val >= minimo(idx)) && (val <= maximo(idx));
    endfunction

    // First field of the group, or -1 without a valid mode
    function automatic int base_modo();
        case ({p_fecha, p_hora, p_temp})
            3'b100: return 3;
            3'b010: return 0;
            3'b001: return 6;
            default: return -1;
        endcase
    endfunction

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] aleatorio();
        estado = xorshift(estado);
        return estado;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus and checking
    ////////////////////////////////////////////////////////////////////////////

    task automatic esperar(input int n);
        repeat (n) @(posedge RELOJ);
        #2;
    endtask

    task automatic comparar(input int obtenido, input int esperado, input string que);
        if (obtenido != esperado)
        begin
            $display("FAILED at time %0t: %s, read %02h, expected %02h",
                     $time, que, obtenido, esperado);
            $display("TEST FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic leer(input int idx);
        int esperado;
        indice_dato = 4'(idx);
        esperar(3);
        esperado = (idx <= 8) ? a_bcd(modelo[idx]) : 0;
        comparar(int'(dato_out), esperado, $sformatf("readback of index %0d", idx));
    endtask

    task automatic leer_todo();
        for (int i = 0; i < 9; i++)
            leer(i);
    endtask

    task automatic cargar_bcd(input int idx, input logic [7:0] b);
        cargar = 1'b1;
        indice_dato = 4'(idx);
        dato_in = b;
        esperar(1);
        cargar = 1'b0;
        if (carga_valida(idx, b))
            modelo[idx] = int'(b[7:4]) * 10 + int'(b[3:0]);
    endtask

    task automatic fijar_modo(input logic f, input logic h, input logic t);
        p_fecha = f;
        p_hora = h;
        p_temp = t;
        esperar(2);
        if (base_modo() < 0)
            cursor = 0;
    endtask

    // Hold 3 cycles, idle 10, then update the model and read everything back
    task automatic pulsar(input int boton);
        int base;
        base = base_modo();
        sumar = (boton == BOTON_SUMAR);
        restar = (boton == BOTON_RESTAR);
        derecha = (boton == BOTON_DERECHA);
        izquierda = (boton == BOTON_IZQUIERDA);
        esperar(3);
        sumar = 1'b0;
        restar = 1'b0;
        derecha = 1'b0;
        izquierda = 1'b0;
        esperar(10);
        if (base < 0)
            cursor = 0;
        else if (boton == BOTON_SUMAR)
            modelo[base + cursor] = paso(modelo[base + cursor], base + cursor, 1'b1);
        else if (boton == BOTON_RESTAR)
            modelo[base + cursor] = paso(modelo[base + cursor], base + cursor, 1'b0);
        else if (boton == BOTON_DERECHA && cursor > 0)
            cursor = cursor - 1;
        else if (boton == BOTON_IZQUIERDA && cursor < `RTC_POS_MAX)
            cursor = cursor + 1;
        leer_todo();
    endtask

    initial
    begin
        #(TIMEOUT_NS);
        $display("Watchdog expired after %0d ns, the run did not finish", TIMEOUT_NS);
        $display("TEST FAIL");
        $fatal(1, "timeout");
    end

    initial
    begin
        int v;
        int idx;
        logic [31:0] r;
        logic [7:0] b;
        estado = SEMILLA;
        RELOJ = 1'b0;
        RESET = 1'b1;
        p_fecha = 1'b0;
        p_hora = 1'b0;
        p_temp = 1'b0;
        sumar = 1'b0;
        restar = 1'b0;
        derecha = 1'b0;
        izquierda = 1'b0;
        cargar = 1'b0;
        indice_dato = '0;
        dato_in = '0;
        for (int i = 0; i < 9; i++)
            modelo[i] = minimo(i);
        cursor = 0;
        repeat (4) @(posedge RELOJ);
        #2;
        RESET = 1'b0;
        esperar(2);

        for (int i = 0; i < 16; i++)
            leer(i);

        // In-range loads everywhere, then a random mix
        for (int i = 0; i < 9; i++)
        begin
            v = minimo(i) + int'(aleatorio() % 32'(maximo(i) - minimo(i) + 1));
            cargar_bcd(i, 8'(a_bcd(v)));
        end
        leer_todo();
        for (int n = 0; n < NUM_CARGAS; n++)
        begin
            r = aleatorio();
            idx = int'(r % 11);
            if (r[9:8] == 2'b00)
                b = r[23:16];
            else
                b = 8'(a_bcd(int'(r[31:16] % 100)));
            cargar_bcd(idx, b);
            leer(idx);
        end

        // Time mode
        fijar_modo(1'b0, 1'b1, 1'b0);
        cargar_bcd(0, 8'h59);
        pulsar(BOTON_SUMAR);
        pulsar(BOTON_RESTAR);
        pulsar(BOTON_IZQUIERDA);
        pulsar(BOTON_IZQUIERDA);
        cargar_bcd(2, 8'h23);
        pulsar(BOTON_SUMAR);
        for (int n = 0; n < NUM_PRUEBAS; n++)
            pulsar(int'(aleatorio() % 4));

        // Date mode
        fijar_modo(1'b1, 1'b0, 1'b0);
        repeat (3) pulsar(BOTON_DERECHA);
        cargar_bcd(3, 8'h31);
        pulsar(BOTON_SUMAR);
        pulsar(BOTON_RESTAR);
        pulsar(BOTON_IZQUIERDA);
        cargar_bcd(4, 8'h12);
        pulsar(BOTON_SUMAR);
        pulsar(BOTON_RESTAR);
        repeat (3) pulsar(BOTON_IZQUIERDA);
        cargar_bcd(5, 8'h99);
        pulsar(BOTON_SUMAR);
        pulsar(BOTON_RESTAR);

        // Timer mode, then blocked modes
        fijar_modo(1'b0, 1'b0, 1'b1);
        repeat (8) pulsar(int'(aleatorio() % 4));
        pulsar(BOTON_IZQUIERDA);
        fijar_modo(1'b0, 1'b0, 1'b0);
        pulsar(BOTON_SUMAR);
        repeat (4) pulsar(int'(aleatorio() % 4));
        fijar_modo(1'b0, 1'b0, 1'b1);
        pulsar(BOTON_SUMAR);
        pulsar(BOTON_IZQUIERDA);
        fijar_modo(1'b1, 1'b1, 1'b0);
        pulsar(BOTON_SUMAR);
        repeat (4) pulsar(int'(aleatorio() % 4));
        fijar_modo(1'b0, 1'b0, 1'b1);
        pulsar(BOTON_SUMAR);

        // Load lands on the same edge as the step on timer seconds
        sumar = 1'b1;
        esperar(3);
        sumar = 1'b0;
        cargar_bcd(6, 8'h42);
        esperar(10);
        leer_todo();

        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== rtc_ajuste_top.f ====
+incdir+hw
hw/rtc_pkg.sv
hw/botones_if.sv
hw/boton_pulsos.sv
hw/selector_campo.sv
hw/banco_registros.sv
hw/rtc_ajuste_top.sv
testbench/rtc_ajuste_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the RTC setting testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --top-module rtc_ajuste_tb \
        -f rtc_ajuste_top.f -o rtc_ajuste_sim; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/rtc_ajuste_sim > "$LOG" 2>&1; then
    cat "$LOG"
    echo "Simulation ended with an error status"
    exit 1
fi
cat "$LOG"

if grep -q "^TEST PASS$" "$LOG"; then
    exit 0
fi

echo "Pass message not found in $LOG"
exit 1
